// File: compile.f
design/rs_pkg.sv
design/rs_entry.sv
design/rs_alloc.sv
design/rs_issue_select.sv
design/rs_station.sv
verif/rs_clock_gen.sv
verif/rs_station_sva.sv
verif/rs_station_tb.sv

// File: design/rs_alloc.sv
/*
 Dispatch allocator for the reservation station.
 Finds the lowest-numbered free entry and raises its load strobe on an
 accepted dispatch. dispatch_ready is high while any entry is free.
 Pure combinational logic.
*/

`default_nettype none

module rs_alloc
	import rs_pkg::*;
(
	input  logic [RS_DEPTH-1:0] entry_in_use,
	input  logic                dispatch_valid,
	output logic                dispatch_ready,
	output logic [RS_DEPTH-1:0] load
);

	logic [RS_DEPTH-1:0] free;
	logic [RS_DEPTH-1:0] first_free;
	logic                found;

	assign free           = ~entry_in_use;
	assign dispatch_ready = |free;

	// Lowest index wins
	always_comb
	begin
		first_free = '0;
		found      = 1'b0;
		for (int i = 0; i < RS_DEPTH; i++)
		begin
			if (free[i] && !found)
			begin
				first_free[i] = 1'b1;
				found         = 1'b1;
			end
		end
	end

	// Strobe only on a real transfer
	assign load = (dispatch_valid && dispatch_ready) ? first_free : '0;

endmodule

`default_nettype wire

// File: design/rs_entry.sv
/*
 One reservation station entry.
 Loads an instruction on its load strobe, watches both result buses for
 the tags of its missing operands, and reports ready once both operands
 hold values. A grant from the issue selector or a flush frees it.
 A broadcast in the load cycle is captured as well.
*/

`default_nettype none

module rs_entry
	import rs_pkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  flush,          // Branch recovery
	input  logic                  load,           // Dispatch into this entry
	input  opnd_word_u            opa_word,
	input  logic                  opa_valid,
	input  opnd_word_u            opb_word,
	input  logic                  opb_valid,
	input  logic [TAG_W-1:0]      dest_tag,
	input  logic [ROB_IDX_W-1:0]  rob_idx,
	input  logic [ALU_FUNC_W-1:0] alu_func,
	input  logic                  cdb1_valid,
	input  logic [TAG_W-1:0]      cdb1_tag,
	input  logic [DATA_W-1:0]     cdb1_value,
	input  logic                  cdb2_valid,
	input  logic [TAG_W-1:0]      cdb2_tag,
	input  logic [DATA_W-1:0]     cdb2_value,
	input  logic                  grant,          // Issued this cycle
	output logic                  in_use,
	output logic                  ready,
	output logic [DATA_W-1:0]     opa,
	output logic [DATA_W-1:0]     opb,
	output logic [TAG_W-1:0]      entry_dest_tag,
	output logic [ROB_IDX_W-1:0]  entry_rob_idx,
	output logic [ALU_FUNC_W-1:0] entry_alu_func
);

	opnd_word_u            opa_q;
	opnd_word_u            opb_q;
	logic                  opa_valid_q;
	logic                  opb_valid_q;
	logic [TAG_W-1:0]      dest_tag_q;
	logic [ROB_IDX_W-1:0]  rob_idx_q;
	logic [ALU_FUNC_W-1:0] alu_func_q;

	opnd_word_u            opa_src;
	opnd_word_u            opb_src;
	logic                  opa_src_valid;
	logic                  opb_src_valid;
	opnd_word_u            opa_d;
	opnd_word_u            opb_d;
	logic                  opa_valid_d;
	logic                  opb_valid_d;
	logic                  live;
	logic                  opa_hit1;
	logic                  opa_hit2;
	logic                  opb_hit1;
	logic                  opb_hit2;

	// Waiting operand whose tag is on a valid bus
	function automatic logic tag_hit(
		input opnd_word_u       word,
		input logic             word_valid,
		input logic             bus_valid,
		input logic [TAG_W-1:0] bus_tag
	);
		tag_hit = bus_valid && !word_valid && (word.tag_view.tag == bus_tag);
	endfunction

	//////////////////////////////
	// Operand capture
	//////////////////////////////

	always_comb
	begin
		live          = load | in_use;               // Snoop only for a live instruction
		opa_src       = load ? opa_word : opa_q;     // Incoming word on the load cycle
		opb_src       = load ? opb_word : opb_q;
		opa_src_valid = load ? opa_valid : opa_valid_q;
		opb_src_valid = load ? opb_valid : opb_valid_q;

		opa_hit1 = live && tag_hit(opa_src, opa_src_valid, cdb1_valid, cdb1_tag);
		opa_hit2 = live && tag_hit(opa_src, opa_src_valid, cdb2_valid, cdb2_tag);
		opb_hit1 = live && tag_hit(opb_src, opb_src_valid, cdb1_valid, cdb1_tag);
		opb_hit2 = live && tag_hit(opb_src, opb_src_valid, cdb2_valid, cdb2_tag);

		opa_d       = opa_src;
		opb_d       = opb_src;
		opa_valid_d = opa_src_valid | opa_hit1 | opa_hit2;
		opb_valid_d = opb_src_valid | opb_hit1 | opb_hit2;

		if (opa_hit2)                   // cdb2 wins a double match
			opa_d.value = cdb2_value;
		else if (opa_hit1)
			opa_d.value = cdb1_value;

		if (opb_hit2)
			opb_d.value = cdb2_value;
		else if (opb_hit1)
			opb_d.value = cdb1_value;
	end

	//////////////////////////////
	// State
	//////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			in_use      <= 1'b0;
			opa_valid_q <= 1'b0;
			opb_valid_q <= 1'b0;
			alu_func_q  <= ALU_DEFAULT;
		end
		else if (flush || grant)        // Flush beats a load
		begin
			in_use      <= 1'b0;
			opa_valid_q <= 1'b0;
			opb_valid_q <= 1'b0;
			alu_func_q  <= ALU_DEFAULT;
		end
		else
		begin
			if (load)
			begin
				in_use     <= 1'b1;
				alu_func_q <= alu_func;
			end
			opa_valid_q <= opa_valid_d;
			opb_valid_q <= opb_valid_d;
		end
	end

	always_ff @(posedge clock)
	begin
		opa_q <= opa_d;                 // Holds itself when idle
		opb_q <= opb_d;
		if (load)
		begin
			dest_tag_q <= dest_tag;
			rob_idx_q  <= rob_idx;
		end
	end

	assign ready          = in_use & opa_valid_q & opb_valid_q;
	assign opa            = opa_q.value;
	assign opb            = opb_q.value;
	assign entry_dest_tag = dest_tag_q;
	assign entry_rob_idx  = rob_idx_q;
	assign entry_alu_func = alu_func_q;

endmodule

`default_nettype wire

// File: design/rs_issue_select.sv
/*
 Issue selector for the reservation station.
 Fixed-priority pick of the lowest-numbered ready entry. Its fields are
 multiplexed onto the issue port, and its grant is raised when the
 functional unit accepts. Pure combinational logic.
*/

`default_nettype none

module rs_issue_select
	import rs_pkg::*;
(
	input  logic [RS_DEPTH-1:0]                 entry_ready,
	input  logic [RS_DEPTH-1:0][DATA_W-1:0]     entry_opa,
	input  logic [RS_DEPTH-1:0][DATA_W-1:0]     entry_opb,
	input  logic [RS_DEPTH-1:0][TAG_W-1:0]      entry_dest_tag,
	input  logic [RS_DEPTH-1:0][ROB_IDX_W-1:0]  entry_rob_idx,
	input  logic [RS_DEPTH-1:0][ALU_FUNC_W-1:0] entry_alu_func,
	input  logic                                issue_accept,
	output logic                                issue_valid,
	output logic [DATA_W-1:0]                   issue_opa,
	output logic [DATA_W-1:0]                   issue_opb,
	output logic [TAG_W-1:0]                    issue_dest_tag,
	output logic [ROB_IDX_W-1:0]                issue_rob_idx,
	output logic [ALU_FUNC_W-1:0]               issue_alu_func,
	output logic [RS_DEPTH-1:0]                 grant
);

	logic [$clog2(RS_DEPTH)-1:0] sel;      // Chosen entry
	logic [RS_DEPTH-1:0]         sel_onehot;

	always_comb
	begin
		sel        = '0;
		sel_onehot = '0;
		for (int i = RS_DEPTH - 1; i >= 0; i--)  // Last hit is the lowest
		begin
			if (entry_ready[i])
			begin
				sel        = i[$clog2(RS_DEPTH)-1:0];
				sel_onehot = RS_DEPTH'(1) << i;
			end
		end
	end

	assign issue_valid    = |entry_ready;
	assign issue_opa      = entry_opa[sel];
	assign issue_opb      = entry_opb[sel];
	assign issue_dest_tag = entry_dest_tag[sel];
	assign issue_rob_idx  = entry_rob_idx[sel];
	assign issue_alu_func = entry_alu_func[sel];

	assign grant = issue_accept ? sel_onehot : '0; // Frees the entry at the edge

endmodule

`default_nettype wire

// File: design/rs_pkg.sv
/*
 Shared sizes and types for the reservation station.
 Every station module imports this package with a wildcard import in
 its module header. The operand word union lets an entry hold either a
 waiting tag or the operand value in the same storage.
*/

`default_nettype none

package rs_pkg;

	//////////////////////////////
	// Sizes
	//////////////////////////////

	localparam int RS_DEPTH   = 4;  // Station entries
	localparam int DATA_W     = 32; // Operand data width
	localparam int TAG_W      = 6;  // 64 physical registers
	localparam int ROB_IDX_W  = 5;  // ROB index with wrap bit
	localparam int ALU_FUNC_W = 4;  // ALU function code

	// Code held by an idle entry
	localparam logic [ALU_FUNC_W-1:0] ALU_DEFAULT = '0;

	//////////////////////////////
	// Operand word
	//////////////////////////////

	// Value once the operand's valid bit is set, tag while it waits
	typedef union packed
	{
		logic [DATA_W-1:0] value; // Operand data
		struct packed
		{
			logic [DATA_W-TAG_W-1:0] unused; // Don't care while waiting
			logic [TAG_W-1:0]        tag;    // Producer's physical tag
		} tag_view;
	} opnd_word_u;

endpackage

`default_nettype wire

// File: design/rs_station.sv
/*
 Reservation station top level.
 Four entries share the dispatch fields and both result buses. The
 allocator steers each dispatch to the lowest free entry, and the issue
 selector sends the lowest ready entry to the functional unit.
 Instances and wires only.
*/

`default_nettype none

module rs_station
	import rs_pkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  flush,
	// Dispatch
	input  logic                  dispatch_valid,
	output logic                  dispatch_ready,
	input  opnd_word_u            opa_word,
	input  logic                  opa_valid,
	input  opnd_word_u            opb_word,
	input  logic                  opb_valid,
	input  logic [TAG_W-1:0]      dest_tag,
	input  logic [ROB_IDX_W-1:0]  rob_idx,
	input  logic [ALU_FUNC_W-1:0] alu_func,
	// Result broadcast
	input  logic                  cdb1_valid,
	input  logic [TAG_W-1:0]      cdb1_tag,
	input  logic [DATA_W-1:0]     cdb1_value,
	input  logic                  cdb2_valid,
	input  logic [TAG_W-1:0]      cdb2_tag,
	input  logic [DATA_W-1:0]     cdb2_value,
	// Issue
	output logic                  issue_valid,
	output logic [DATA_W-1:0]     issue_opa,
	output logic [DATA_W-1:0]     issue_opb,
	output logic [TAG_W-1:0]      issue_dest_tag,
	output logic [ROB_IDX_W-1:0]  issue_rob_idx,
	output logic [ALU_FUNC_W-1:0] issue_alu_func,
	input  logic                  issue_accept
);

	logic [RS_DEPTH-1:0]                 entry_in_use;
	logic [RS_DEPTH-1:0]                 entry_ready;
	logic [RS_DEPTH-1:0]                 load;
	logic [RS_DEPTH-1:0]                 grant;
	logic [RS_DEPTH-1:0][DATA_W-1:0]     entry_opa;
	logic [RS_DEPTH-1:0][DATA_W-1:0]     entry_opb;
	logic [RS_DEPTH-1:0][TAG_W-1:0]      entry_dest_tag;
	logic [RS_DEPTH-1:0][ROB_IDX_W-1:0]  entry_rob_idx;
	logic [RS_DEPTH-1:0][ALU_FUNC_W-1:0] entry_alu_func;

	//////////////////////////////
	// Entries
	//////////////////////////////

	for (genvar i = 0; i < RS_DEPTH; i++)
	begin : g_entry
		rs_entry entry0 (
			.clock          (clock),
			.reset          (reset),
			.flush          (flush),
			.load           (load[i]),
			.opa_word       (opa_word),
			.opa_valid      (opa_valid),
			.opb_word       (opb_word),
			.opb_valid      (opb_valid),
			.dest_tag       (dest_tag),
			.rob_idx        (rob_idx),
			.alu_func       (alu_func),
			.cdb1_valid     (cdb1_valid),
			.cdb1_tag       (cdb1_tag),
			.cdb1_value     (cdb1_value),
			.cdb2_valid     (cdb2_valid),
			.cdb2_tag       (cdb2_tag),
			.cdb2_value     (cdb2_value),
			.grant          (grant[i]),
			.in_use         (entry_in_use[i]),
			.ready          (entry_ready[i]),
			.opa            (entry_opa[i]),
			.opb            (entry_opb[i]),
			.entry_dest_tag (entry_dest_tag[i]),
			.entry_rob_idx  (entry_rob_idx[i]),
			.entry_alu_func (entry_alu_func[i])
		);
	end

	//////////////////////////////
	// Allocation and issue
	//////////////////////////////

	rs_alloc alloc0 (
		.entry_in_use   (entry_in_use),
		.dispatch_valid (dispatch_valid),
		.dispatch_ready (dispatch_ready),
		.load           (load)
	);

	rs_issue_select select0 (
		.entry_ready    (entry_ready),
		.entry_opa      (entry_opa),
		.entry_opb      (entry_opb),
		.entry_dest_tag (entry_dest_tag),
		.entry_rob_idx  (entry_rob_idx),
		.entry_alu_func (entry_alu_func),
		.issue_accept   (issue_accept),
		.issue_valid    (issue_valid),
		.issue_opa      (issue_opa),
		.issue_opb      (issue_opb),
		.issue_dest_tag (issue_dest_tag),
		.issue_rob_idx  (issue_rob_idx),
		.issue_alu_func (issue_alu_func),
		.grant          (grant)
	);

endmodule

`default_nettype wire

// File: verif/rs_clock_gen.sv
/*
 Testbench clock and reset source.
 Free-running clock of period 100, reset held high for the first 16
 rising edges and released just after the last of them.
*/

`default_nettype none

module rs_clock_gen
(
	output logic clock,
	output logic reset
);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;    // Period 100
	end

	initial
	begin
		reset = 1'b1;
		repeat (16) @(posedge clock);
		#1 reset = 1'b0;               // Off the edge
	end

endmodule

`default_nettype wire

// File: verif/rs_station_sva.sv
/*
 Assertions on the reservation station handshakes and entry state.
 Bound into every rs_station instance. Checks grant encoding, issue
 validity, issue port stability under back-pressure and dispatch stall.
*/

`default_nettype none

module rs_station_sva
	import rs_pkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  flush,
	input  logic                  dispatch_ready,
	input  logic                  issue_valid,
	input  logic                  issue_accept,
	input  logic [DATA_W-1:0]     issue_opa,
	input  logic [DATA_W-1:0]     issue_opb,
	input  logic [TAG_W-1:0]      issue_dest_tag,
	input  logic [ROB_IDX_W-1:0]  issue_rob_idx,
	input  logic [ALU_FUNC_W-1:0] issue_alu_func,
	input  logic [RS_DEPTH-1:0]   entry_ready,
	input  logic [RS_DEPTH-1:0]   entry_in_use,
	input  logic [RS_DEPTH-1:0]   grant
);

	logic [$clog2(RS_DEPTH)-1:0] low_idx;  // Lowest ready entry
	int                          failures = 0;

	always_comb
	begin
		low_idx = '0;
		for (int i = RS_DEPTH - 1; i >= 0; i--)
		begin
			if (entry_ready[i])
				low_idx = i[$clog2(RS_DEPTH)-1:0];
		end
	end

	grant_onehot: assert property (@(posedge clock) disable iff (reset)
		$onehot0(grant) && ((grant & ~entry_ready) == '0))
		else
		begin
			$error("grant not one-hot or on an entry that is not ready");
			failures++;
		end

	valid_has_ready: assert property (@(posedge clock) disable iff (reset)
		issue_valid |-> |entry_ready)
		else
		begin
			$error("issue_valid without a ready entry");
			failures++;
		end

	// Only a newly ready lower entry may take over the issue port
	hold_when_stalled: assert property (@(posedge clock) disable iff (reset)
		(issue_valid && !issue_accept && !flush) |=>
			issue_valid &&
			((low_idx < $past(low_idx)) ||
			 ($stable(issue_opa) && $stable(issue_opb) &&
			  $stable(issue_dest_tag) && $stable(issue_rob_idx) &&
			  $stable(issue_alu_func))))
		else
		begin
			$error("issue fields changed under back-pressure");
			failures++;
		end

	stall_only_full: assert property (@(posedge clock) disable iff (reset)
		!dispatch_ready |-> &entry_in_use)
		else
		begin
			$error("dispatch stalled with a free entry");
			failures++;
		end

endmodule

bind rs_station rs_station_sva sva0 (
	.clock          (clock),
	.reset          (reset),
	.flush          (flush),
	.dispatch_ready (dispatch_ready),
	.issue_valid    (issue_valid),
	.issue_accept   (issue_accept),
	.issue_opa      (issue_opa),
	.issue_opb      (issue_opb),
	.issue_dest_tag (issue_dest_tag),
	.issue_rob_idx  (issue_rob_idx),
	.issue_alu_func (issue_alu_func),
	.entry_ready    (entry_ready),
	.entry_in_use   (entry_in_use),
	.grant          (grant)
);

`default_nettype wire

// File: verif/rs_station_tb.sv
/*
 Testbench for the reservation station.
 Applies a table of one-cycle steps (dispatch, both result buses, issue
 accept, flush) and compares dispatch_ready and the issue port each cycle
 with a four-slot reference model. One line per test, then a count line.
*/

`default_nettype none

module rs_station_tb
	import rs_pkg::*;
();

	localparam int NUM_TESTS      = 6;
	localparam int NUM_STEPS      = 43;
	localparam int RESET_CYCLES   = 16;
	localparam int TIMEOUT_MARGIN = 20;
	localparam int CYCLE_LIMIT    = NUM_STEPS + RESET_CYCLES + TIMEOUT_MARGIN;
	localparam int SEED           = 32'ha683;

	typedef struct packed
	{
		logic [3:0]       test;
		logic             dv;      // Dispatch valid
		logic             av;      // Operand a valid at dispatch
		logic [TAG_W-1:0] atag;
		logic             bv;
		logic [TAG_W-1:0] btag;
		logic             c1v;
		logic [TAG_W-1:0] c1tag;
		logic             c2v;
		logic [TAG_W-1:0] c2tag;
		logic             acc;     // Issue accept
		logic             fl;      // Flush
	} step_t;

	//////////////////////////////
	// Step table
	//////////////////////////////

	localparam step_t STEPS [NUM_STEPS] = '{
		// test  dv  av  atag   bv  btag   c1  c1tag  c2  c2tag  acc fl
		'{4'd1, '1, '1, 6'h00, '1, 6'h00, '0, 6'h00, '0, 6'h00, '1, '0},
		'{4'd1, '0, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, 6'h00, '1, '0},
		'{4'd1, '0, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, '0},
		'{4'd2, '1, '0, 6'h11, '0, 6'h12, '0, 6'h00, '0, 6'h00, '1, '0},
		'{4'd2, '0, '0, 6'h00, '0, 6'h00, '1, 6'h11, '0, 6'h00, '1, '0},
		'{4'd2, '0, '0, 6'h00, '0, 6'h00, '1, 6'h12, '1, 6'h12, '1, '0},
		'{4'd2, '0, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, 6'h00, '1, '0},
		'{4'd2, '1, '1, 6'h00, '0, 6'h13, '0, 6'h00, '0, 6'h00, '0, '0},
		'{4'd2, '0, '0, 6'h00, '0, 6'h00, '0, 6'h00, '1, 6'h13, '0, '0},
		'{4'd2, '0, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, 6'h00, '1, '0},
		'{4'd2, '0, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, '0},
		'{4'd3, '1, '0, 6'h14, '0, 6'h15, '1, 6'h14, '1, 6'h15, '1, '0},
		'{4'd3, '0, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, 6'h00, '1, '0},
		'{4'd3, '0, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, '0},
		'{4'd4, '1, '1, 6'h00, '1, 6'h00, '0, 6'h00, '0, 6'h00, '0, '0},
		'{4'd4, '1, '1, 6'h00, '1, 6'h00, '0, 6'h00, '0, 6'h00, '0, '0},
		'{4'd4, '1, '0, 6'h16, '1, 6'h00, '0, 6'h00, '0, 6'h00, '0, '0},
		'{4'd4, '1, '1, 6'h00, '1, 6'h00, '0, 6'h00, '0, 6'h00, '0, '0},
		'{4'd4, '1, '1, 6'h00, '1, 6'h00, '0, 6'h00, '0, 6'h00, '0, '0},
		'{4'd4, '0, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, '0},
		'{4'd4, '0, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, 6'h00, '1, '0},
		'{4'd4, '0, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, 6'h00, '1, '0},
		'{4'd4, '0, '0, 6'h00, '0, 6'h00, '1, 6'h16, '0, 6'h00, '0, '0},
		'{4'd4, '0, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, '0},
		'{4'd4, '0, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, 6'h00, '1, '0},
		'{4'd4, '0, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, 6'h00, '1, '0},
		'{4'd4, '0, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, '0},
		'{4'd5, '1, '0, 6'h17, '1, 6'h00, '0, 6'h00, '0, 6'h00, '0, '0},
		'{4'd5, '1, '1, 6'h00, '0, 6'h18, '0, 6'h00, '0, 6'h00, '0, '0},
		'{4'd5, '1, '1, 6'h00, '1, 6'h00, '0, 6'h00, '0, 6'h00, '0, '0},
		'{4'd5, '1, '1, 6'h00, '1, 6'h00, '0, 6'h00, '0, 6'h00, '0, '1},
		'{4'd5, '0, '0, 6'h00, '0, 6'h00, '1, 6'h17, '1, 6'h18, '1, '0},
		'{4'd5, '0, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, 6'h00, '1, '0},
		'{4'd6, '1, '0, 6'h19, '1, 6'h00, '0, 6'h00, '0, 6'h00, '0, '0},
		'{4'd6, '1, '1, 6'h00, '1, 6'h00, '0, 6'h00, '0, 6'h00, '0, '0},
		'{4'd6, '0, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, 6'h00, '1, '0},
		'{4'd6, '1, '1, 6'h00, '1, 6'h00, '0, 6'h00, '0, 6'h00, '0, '0},
		'{4'd6, '1, '1, 6'h00, '1, 6'h00, '0, 6'h00, '1, 6'h19, '0, '0},
		'{4'd6, '0, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, '0},
		'{4'd6, '0, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, 6'h00, '1, '0},
		'{4'd6, '0, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, 6'h00, '1, '0},
		'{4'd6, '0, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, 6'h00, '1, '0},
		'{4'd6, '0, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, 6'h00, '0, '0}
	};

	string test_name [NUM_TESTS] = '{"ready operands", "broadcast wakeup",
		"same-cycle capture", "full station", "flush", "issue order"};

	logic                  clock;
	logic                  reset;
	logic                  flush;
	logic                  dispatch_valid;
	logic                  dispatch_ready;
	opnd_word_u            opa_word;
	logic                  opa_valid;
	opnd_word_u            opb_word;
	logic                  opb_valid;
	logic [TAG_W-1:0]      dest_tag;
	logic [ROB_IDX_W-1:0]  rob_idx;
	logic [ALU_FUNC_W-1:0] alu_func;
	logic                  cdb1_valid;
	logic [TAG_W-1:0]      cdb1_tag;
	logic [DATA_W-1:0]     cdb1_value;
	logic                  cdb2_valid;
	logic [TAG_W-1:0]      cdb2_tag;
	logic [DATA_W-1:0]     cdb2_value;
	logic                  issue_valid;
	logic [DATA_W-1:0]     issue_opa;
	logic [DATA_W-1:0]     issue_opb;
	logic [TAG_W-1:0]      issue_dest_tag;
	logic [ROB_IDX_W-1:0]  issue_rob_idx;
	logic [ALU_FUNC_W-1:0] issue_alu_func;
	logic                  issue_accept;

	// Reference model slots
	logic                  slot_used [RS_DEPTH];
	logic                  slot_av [RS_DEPTH];
	logic                  slot_bv [RS_DEPTH];
	logic [DATA_W-1:0]     slot_a [RS_DEPTH];
	logic [DATA_W-1:0]     slot_b [RS_DEPTH];
	logic [TAG_W-1:0]      slot_dest [RS_DEPTH];
	logic [ROB_IDX_W-1:0]  slot_rob [RS_DEPTH];
	logic [ALU_FUNC_W-1:0] slot_func [RS_DEPTH];

	int step_idx     = 0;
	int cycles       = 0;
	int checks       = 0;
	int errors       = 0;
	int test_errors  = 0;
	int tests_failed = 0;

	rs_clock_gen clock_gen0 (
		.clock (clock),
		.reset (reset)
	);

	rs_station dut0 (.*);

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic int lowest_ready();
		int i;
		lowest_ready = -1;
		for (i = RS_DEPTH - 1; i >= 0; i--)
			if (slot_used[i] && slot_av[i] && slot_bv[i])
				lowest_ready = i;
	endfunction

	function automatic int lowest_free();
		int i;
		lowest_free = -1;
		for (i = RS_DEPTH - 1; i >= 0; i--)
			if (!slot_used[i])
				lowest_free = i;
	endfunction

	// New {valid, word} of one operand, cdb2 checked first
	function automatic logic [DATA_W:0] snoop(input logic v, input logic [DATA_W-1:0] w);
		if (!v && cdb2_valid && w[TAG_W-1:0] == cdb2_tag)
			return {1'b1, cdb2_value};
		if (!v && cdb1_valid && w[TAG_W-1:0] == cdb1_tag)
			return {1'b1, cdb1_value};
		return {v, w};
	endfunction

	task automatic update_model();
		int g;
		int f;
		int i;
		logic [DATA_W:0] r;
		g = lowest_ready();
		f = lowest_free();              // Slot freed this edge not yet usable
		for (i = 0; i < RS_DEPTH; i++)
			if (flush)
				slot_used[i] = 1'b0;
		if (!flush)
		begin
			if (issue_accept && g >= 0)
				slot_used[g] = 1'b0;
			if (dispatch_valid && f >= 0)
			begin
				slot_used[f] = 1'b1;
				slot_av[f]   = opa_valid;
				slot_a[f]    = opa_word.value;
				slot_bv[f]   = opb_valid;
				slot_b[f]    = opb_word.value;
				slot_dest[f] = dest_tag;
				slot_rob[f]  = rob_idx;
				slot_func[f] = alu_func;
			end
			for (i = 0; i < RS_DEPTH; i++)
			begin
				if (slot_used[i])       // Includes a slot loaded this edge
				begin
					r          = snoop(slot_av[i], slot_a[i]);
					slot_av[i] = r[DATA_W];
					slot_a[i]  = r[DATA_W-1:0];
					r          = snoop(slot_bv[i], slot_b[i]);
					slot_bv[i] = r[DATA_W];
					slot_b[i]  = r[DATA_W-1:0];
				end
			end
		end
	endtask

	//////////////////////////////
	// Drive and check
	//////////////////////////////

	task automatic compare(input string name, input logic [DATA_W-1:0] actual,
		input logic [DATA_W-1:0] expected);
		checks++;
		if (actual !== expected)
		begin
			$display("ERR %s got 0x%h expected 0x%h at step %0d", name, actual, expected,
				step_idx);
			errors++;
			test_errors++;
		end
	endtask

	task automatic apply_step(input step_t s);
		dispatch_valid = s.dv;
		opa_valid      = s.av;
		opb_valid      = s.bv;
		opa_word.value = $urandom;
		opb_word.value = $urandom;
		if (!s.av)
			opa_word.tag_view.tag = s.atag;  // Random upper bits stay
		if (!s.bv)
			opb_word.tag_view.tag = s.btag;
		dest_tag     = TAG_W'($urandom);
		rob_idx      = ROB_IDX_W'($urandom);
		alu_func     = ALU_FUNC_W'($urandom);
		cdb1_valid   = s.c1v;
		cdb1_tag     = s.c1tag;
		cdb1_value   = $urandom;
		cdb2_valid   = s.c2v;
		cdb2_tag     = s.c2tag;
		cdb2_value   = $urandom;
		issue_accept = s.acc;
		flush        = s.fl;
	endtask

	task automatic check_outputs();
		int r;
		r = lowest_ready();
		compare("dispatch_ready", DATA_W'(dispatch_ready), DATA_W'(lowest_free() >= 0));
		compare("issue_valid", DATA_W'(issue_valid), DATA_W'(r >= 0));
		if (r >= 0)
		begin
			compare("issue_opa", issue_opa, slot_a[r]);
			compare("issue_opb", issue_opb, slot_b[r]);
			compare("issue_dest_tag", DATA_W'(issue_dest_tag), DATA_W'(slot_dest[r]));
			compare("issue_rob_idx", DATA_W'(issue_rob_idx), DATA_W'(slot_rob[r]));
			compare("issue_alu_func", DATA_W'(issue_alu_func), DATA_W'(slot_func[r]));
		end
	endtask

	task automatic report_test(input int t);
		if (test_errors == 0)
			$display("test %0d %s: ok", t, test_name[t-1]);
		else
		begin
			$display("test %0d %s: %0d mismatches", t, test_name[t-1], test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	always @(posedge clock)
	begin
		cycles++;
		if (cycles > CYCLE_LIMIT)
		begin
			$display("Timeout: step table not finished after %0d cycles", cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	initial
	begin
		void'($urandom(SEED));
		apply_step('0);                 // All inputs idle
		for (int i = 0; i < RS_DEPTH; i++)
			slot_used[i] = 1'b0;
		@(negedge reset);
		for (step_idx = 0; step_idx < NUM_STEPS; step_idx++)
		begin
			@(posedge clock);
			#10;
			apply_step(STEPS[step_idx]);
			#40;                        // Outputs settled, mid cycle
			check_outputs();
			update_model();
			if (step_idx == NUM_STEPS - 1 || STEPS[step_idx + 1].test != STEPS[step_idx].test)
				report_test(STEPS[step_idx].test);
		end
		$display("%0d tests, %0d failed, %0d checks, %0d mismatches, %0d assertion failures",
			NUM_TESTS, tests_failed, checks, errors, dut0.sva0.failures);
		if (errors == 0 && dut0.sva0.failures == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
